/* logic/histPkg.sv */
package histPkg;

    // run phase seen by the datapath
    typedef enum logic [1:0] {
        phaseIdle  = 2'd0,  // no RAM traffic, pipeline may still drain
        phaseClear = 2'd1,  // zero sweep over all bins
        phaseAcc   = 2'd2,  // events accepted
        phaseRead  = 2'd3   // bins streamed out in address order
    } histPhase_e;

    // The bin RAM returns read data one clock after rdEn. The accumulator
    // pipeline and its forwarding paths are laid out for exactly this delay.
    localparam int ramLatency = 1;

endpackage

/* logic/histBinRam.sv */
`timescale 1ns/1ps

module histBinRam #(
    parameter int binBits   = 4,
    parameter int countBits = 4
) (
    input  logic                 clk,
    input  logic                 wrEn,
    input  logic [binBits-1:0]   wrAddr,
    input  logic [countBits-1:0] wrData,
    input  logic                 rdEn,
    input  logic [binBits-1:0]   rdAddr,
    output logic [countBits-1:0] rdData
);

    localparam int numBins = 2 ** binBits;

    logic [countBits-1:0] mem [numBins];  // one count per bin

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read, old data on same-address collision
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

/* logic/histAccumulator.sv */
`timescale 1ns/1ps

module histAccumulator import histPkg::*; #(
    parameter int binBits   = 4,
    parameter int countBits = 4
) (
    input  logic                 clk,
    input  logic                 res,
    input  histPhase_e           phase,
    input  logic [binBits-1:0]   sweepAddr,
    input  logic [binBits-1:0]   data,
    input  logic                 dataValid,
    input  logic [countBits-1:0] rdData,
    output logic                 eventTaken,
    output logic                 wrEn,
    output logic [binBits-1:0]   wrAddr,
    output logic [countBits-1:0] wrData,
    output logic                 rdEn,
    output logic [binBits-1:0]   rdAddr,
    output logic                 outValid,
    output logic [binBits-1:0]   outAddr,
    output logic [countBits-1:0] outCount
);

    localparam logic [countBits-1:0] maxCount = '1;

    logic                 evValid;     // event waiting for its read data
    logic [binBits-1:0]   evAddr;
    logic                 prevWrEn;    // write committed one cycle earlier
    logic [binBits-1:0]   prevWrAddr;
    logic [countBits-1:0] prevWrData;
    logic [countBits-1:0] baseCount;   // freshest count of evAddr
    logic [countBits-1:0] nextCount;
    logic                 clearPhase;
    logic                 readPhase;

    assign clearPhase = (phase == phaseClear);
    assign readPhase  = (phase == phaseRead);

    // only strobes inside the accumulate phase count
    assign eventTaken = (phase == phaseAcc) && dataValid;

    // read port is shared by the event lookup and the readout sweep
    assign rdEn   = eventTaken || readPhase;
    assign rdAddr = readPhase ? sweepAddr : data;

    // Stage 1 is the strobe cycle: the read goes out and the event is
    // registered. Stage 2 sees rdData one cycle later. Up to two writes
    // to the same bin may not be visible in rdData yet. The one sitting
    // in the write register lands this cycle, and the one before it
    // collided with our read, which returned the old value.
    always_comb begin
        if (wrEn && (wrAddr == evAddr)) begin
            baseCount = wrData;          // newest write wins
        end else if (prevWrEn && (prevWrAddr == evAddr)) begin
            baseCount = prevWrData;
        end else begin
            baseCount = rdData;
        end
    end

    // hold at full scale instead of wrapping
    assign nextCount = (baseCount == maxCount) ? maxCount : baseCount + 1'b1;

    // stage control
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            evValid  <= 1'b0;
            wrEn     <= 1'b0;
            prevWrEn <= 1'b0;
            outValid <= 1'b0;
        end else begin
            evValid  <= eventTaken;
            wrEn     <= clearPhase || evValid;
            prevWrEn <= wrEn;
            outValid <= readPhase;  // data follows the read by one clock
        end
    end

    // stage payload
    always_ff @(posedge clk) begin
        evAddr <= data;
        if (clearPhase) begin
            wrAddr <= sweepAddr;
            wrData <= '0;           // zero sweep
        end else begin
            wrAddr <= evAddr;
            wrData <= nextCount;
        end
        prevWrAddr <= wrAddr;
        prevWrData <= wrData;
        outAddr    <= sweepAddr;    // aligned with rdData
    end

    assign outCount = rdData;

endmodule

/* logic/histController.sv */
`timescale 1ns/1ps

module histController import histPkg::*; #(
    parameter int binBits   = 4,
    parameter int acqLength = 40
) (
    input  logic               clk,
    input  logic               res,
    input  logic               start,
    input  logic               eventTaken,
    output histPhase_e         phase,
    output logic [binBits-1:0] sweepAddr,
    output logic               acquiring,
    output logic               done
);

    localparam int cntBits     = $clog2(acqLength + 1);
    localparam int drainCycles = ramLatency + 1;  // read stage plus write stage
    localparam int drainBits   = $clog2(drainCycles + 1);

    localparam logic [binBits-1:0]   lastAddr  = '1;
    localparam logic [cntBits-1:0]   lastEvent = cntBits'(acqLength - 1);
    localparam logic [drainBits-1:0] lastDrain = drainBits'(drainCycles - 1);

    localparam logic [2:0] stIdle  = 3'd0;
    localparam logic [2:0] stClear = 3'd1;
    localparam logic [2:0] stAcc   = 3'd2;
    localparam logic [2:0] stDrain = 3'd3;
    localparam logic [2:0] stRead  = 3'd4;

    logic [2:0]           state;
    logic [cntBits-1:0]   eventCount;  // events taken this run
    logic [drainBits-1:0] drainCount;
    logic                 lastRead;    // last bin read issued one cycle ago

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= stIdle;
            sweepAddr  <= '0;
            eventCount <= '0;
            drainCount <= '0;
            lastRead   <= 1'b0;
            done       <= 1'b0;
        end else begin
            lastRead <= (state == stRead) && (sweepAddr == lastAddr);
            done     <= lastRead;  // last outValid has just left
            case (state)
                stIdle: begin
                    if (start && !lastRead) begin  // still busy while lastRead
                        state     <= stClear;
                        sweepAddr <= '0;
                    end
                end
                stClear: begin
                    sweepAddr <= sweepAddr + 1'b1;  // wraps to 0 for the readout
                    if (sweepAddr == lastAddr) begin
                        state      <= stAcc;
                        eventCount <= '0;
                    end
                end
                stAcc: begin
                    if (eventTaken) begin
                        if (eventCount == lastEvent) begin
                            state      <= stDrain;
                            drainCount <= '0;
                        end else begin
                            eventCount <= eventCount + 1'b1;
                        end
                    end
                end
                stDrain: begin
                    if (drainCount == lastDrain) begin
                        state <= stRead;
                    end else begin
                        drainCount <= drainCount + 1'b1;
                    end
                end
                stRead: begin
                    sweepAddr <= sweepAddr + 1'b1;
                    if (sweepAddr == lastAddr) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // drain shows as idle so no new event gets in
    always_comb begin
        case (state)
            stClear: phase = phaseClear;
            stAcc:   phase = phaseAcc;
            stRead:  phase = phaseRead;
            default: phase = phaseIdle;
        endcase
    end

    assign acquiring = (state == stAcc);

endmodule

/* logic/histTop.sv */
`timescale 1ns/1ps

module histTop import histPkg::*; #(
    parameter int binBits   = 4,
    parameter int countBits = 4,
    parameter int acqLength = 40
) (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 start,
    input  logic [binBits-1:0]   data,
    input  logic                 dataValid,
    output logic                 acquiring,
    output logic                 outValid,
    output logic [binBits-1:0]   outAddr,
    output logic [countBits-1:0] outCount,
    output logic                 done
);

    histPhase_e           phase;
    logic [binBits-1:0]   sweepAddr;   // bin being cleared or read
    logic                 eventTaken;
    logic                 wrEn;
    logic [binBits-1:0]   wrAddr;
    logic [countBits-1:0] wrData;
    logic                 rdEn;
    logic [binBits-1:0]   rdAddr;
    logic [countBits-1:0] rdData;

    histController #(
        .binBits   (binBits),
        .acqLength (acqLength)
    ) ctrl_i (
        .clk        (clk),
        .res        (res),
        .start      (start),
        .eventTaken (eventTaken),
        .phase      (phase),
        .sweepAddr  (sweepAddr),
        .acquiring  (acquiring),
        .done       (done)
    );

    histAccumulator #(
        .binBits   (binBits),
        .countBits (countBits)
    ) acc_i (
        .clk        (clk),
        .res        (res),
        .phase      (phase),
        .sweepAddr  (sweepAddr),
        .data       (data),
        .dataValid  (dataValid),
        .rdData     (rdData),
        .eventTaken (eventTaken),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .rdEn       (rdEn),
        .rdAddr     (rdAddr),
        .outValid   (outValid),
        .outAddr    (outAddr),
        .outCount   (outCount)
    );

    histBinRam #(
        .binBits   (binBits),
        .countBits (countBits)
    ) ram_i (
        .clk    (clk),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

endmodule

/* testbench/histTb_assert.sv */
`timescale 1ns/1ps

module histTb_assert import histPkg::*; #(
    parameter int binBits = 4
) (
    input logic               clk,
    input logic               res,
    input logic               acquiring,
    input logic               outValid,
    input logic [binBits-1:0] outAddr,
    input logic               done,
    input histPhase_e         phase,
    input logic               wrEn
);

    int failCount = 0;  // polled by the testbench at the end

    doneOnePulse: assert property (@(posedge clk) disable iff (!res) done |=> !done)
        else begin
            failCount++;
            $error("done stayed high for two cycles");
        end

    streamNotAcquiring: assert property (@(posedge clk) disable iff (!res)
        !(outValid && acquiring))
        else begin
            failCount++;
            $error("outValid and acquiring high together");
        end

    noWriteInRead: assert property (@(posedge clk) disable iff (!res)
        (phase == phaseRead) |-> !wrEn)
        else begin
            failCount++;
            $error("RAM written during the read phase");
        end

    // addresses step by one within a readout burst
    addrStep: assert property (@(posedge clk) disable iff (!res)
        (outValid && $past(outValid)) |-> (outAddr == binBits'($past(outAddr) + 1)))
        else begin
            failCount++;
            $error("outAddr did not step by one");
        end

endmodule

bind histTop histTb_assert #(.binBits(binBits)) assert_i (
    .clk       (clk),
    .res       (res),
    .acquiring (acquiring),
    .outValid  (outValid),
    .outAddr   (outAddr),
    .done      (done),
    .phase     (phase),
    .wrEn      (wrEn)
);

/* testbench/histTb.sv */
`timescale 1ns/1ps

module histTb;

    localparam int binBits   = 4;
    localparam int countBits = 4;
    localparam int acqLength = 40;
    localparam int numBins   = 2 ** binBits;
    localparam int maxCount  = 2 ** countBits - 1;

    // 2 runs x (1 start + 16 clear + 40 x 4 events + 2 drain + 16 read + 1) = 392,
    // plus 10 reset cycles, doubled for margin
    localparam int timeoutCycles = 800;

    logic                 clk;
    logic                 res;
    logic                 start;
    logic [binBits-1:0]   data;
    logic                 dataValid;
    logic                 acquiring;
    logic                 outValid;
    logic [binBits-1:0]   outAddr;
    logic [countBits-1:0] outCount;
    logic                 done;

    logic [7:0]         eventTable [acqLength];  // {gap, bin} per event
    logic [binBits-1:0] runBins [acqLength];     // bins used by the current run
    int                 expCount [numBins];      // reference histogram
    int                 seed;
    int                 cycleCount;

    histTop #(
        .binBits   (binBits),
        .countBits (countBits),
        .acqLength (acqLength)
    ) dut_i (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .data      (data),
        .dataValid (dataValid),
        .acquiring (acquiring),
        .outValid  (outValid),
        .outAddr   (outAddr),
        .outCount  (outCount),
        .done      (done)
    );

    always #2 clk = ~clk;  // 4 ns period

    // hang guard
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: no done pulse after %0d clock cycles", timeoutCycles);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic checkQuiet();
        checkValue("acquiring", acquiring, 0);
        checkValue("outValid", outValid, 0);
        checkValue("done", done, 0);
    endtask

    // strobes that must not be counted
    task automatic sendStrays(input logic [binBits-1:0] bin, input int count);
        repeat (count) begin
            @(posedge clk);
            data      <= bin;
            dataValid <= 1'b1;
        end
        @(posedge clk);
        dataValid <= 1'b0;
    endtask

    // One full run: clear, accumulate runBins with the table gaps, readout.
    task automatic runHistogram();
        int row;
        int gap;
        int readIdx;
        bit lastOut;
        bit finished;
        for (int b = 0; b < numBins; b++) begin
            expCount[b] = 0;
        end
        for (row = 0; row < acqLength; row++) begin
            if (expCount[runBins[row]] < maxCount) begin
                expCount[runBins[row]]++;  // capped at full scale
            end
        end

        @(posedge clk);
        start     <= 1'b1;
        data      <= 4'h5;
        dataValid <= 1'b1;  // stray strobe along with start
        @(posedge clk);
        start     <= 1'b0;
        repeat (6) @(posedge clk);
        dataValid <= 1'b0;  // strobes above fall into the clear sweep

        @(negedge clk);
        while (!acquiring) begin
            @(negedge clk);
        end

        for (row = 0; row < acqLength; row++) begin
            gap = eventTable[row][7:4];
            repeat (gap) begin
                @(posedge clk);
                dataValid <= 1'b0;
            end
            @(posedge clk);
            data      <= runBins[row];
            dataValid <= 1'b1;
            @(negedge clk);
            checkValue("acquiring", acquiring, 1);
        end
        @(posedge clk);
        data      <= 4'h5;
        dataValid <= 1'b1;  // one past the limit
        @(negedge clk);
        checkValue("acquiring", acquiring, 0);

        readIdx  = 0;
        lastOut  = 0;
        finished = 0;
        while (!finished) begin
            @(posedge clk);
            dataValid <= ~dataValid;  // keep poking during drain and readout
            @(negedge clk);
            checkValue("acquiring", acquiring, 0);
            checkValue("done", done, lastOut);  // one cycle after the last bin
            if (done) begin
                checkValue("outValid", outValid, 0);
                finished = 1;
            end else if (outValid) begin
                checkValue("outAddr", outAddr, readIdx);
                checkValue("outCount", outCount, expCount[readIdx]);
                readIdx++;
            end
            lastOut = (readIdx == numBins);
        end
        @(posedge clk);
        dataValid <= 1'b0;
    endtask

    initial begin
        clk        = 1'b0;
        res        = 1'b0;
        start      = 1'b0;
        data       = '0;
        dataValid  = 1'b0;
        cycleCount = 0;
        seed       = 64;

        // bin 5 gets 20 events, 2/3 alternate back to back
        eventTable = '{
            8'h15, 8'h05, 8'h05, 8'h05, 8'h21, 8'h02, 8'h03, 8'h02,
            8'h03, 8'h05, 8'h05, 8'h35, 8'h05, 8'h10, 8'h0F, 8'h05,
            8'h05, 8'h05, 8'h27, 8'h07, 8'h15, 8'h09, 8'h05, 8'h09,
            8'h05, 8'h3C, 8'h02, 8'h03, 8'h02, 8'h03, 8'h05, 8'h05,
            8'h05, 8'h15, 8'h0E, 8'h25, 8'h08, 8'h05, 8'h1B, 8'h04
        };

        repeat (10) begin
            @(posedge clk);
            @(negedge clk);
            checkQuiet();
        end
        @(posedge clk);
        res <= 1'b1;
        @(negedge clk);
        checkQuiet();

        sendStrays(4'h5, 3);  // idle, before any start

        for (int row = 0; row < acqLength; row++) begin
            runBins[row] = eventTable[row][3:0];
        end
        runHistogram();

        sendStrays(4'h3, 2);

        for (int row = 0; row < acqLength; row++) begin
            runBins[row] = binBits'($random(seed));  // gaps still from the table
        end
        runHistogram();

        repeat (3) @(posedge clk);
        if (dut_i.assert_i.failCount == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("%0d assertion failures were reported", dut_i.assert_i.failCount);
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

/* tb.f */
logic/histPkg.sv
logic/histBinRam.sv
logic/histAccumulator.sv
logic/histController.sv
logic/histTop.sv
testbench/histTb_assert.sv
testbench/histTb.sv
